// ==== source/nocPkg.sv ====
package nocPkg;

  // **************************************************************************
  // Widths and counts.
  // **************************************************************************

  localparam int LengthWidth = 12; // Packet length and hold timer width.
  localparam int PortCount = 5;
  localparam int DefaultDataWidth = 16;

  // **************************************************************************
  // Encodings.
  // **************************************************************************

  typedef enum logic [2:0] {
    kindNone = 3'd0,
    kindHead = 3'd1,
    kindBody = 3'd2,
    kindTail = 3'd3
  } flitKind;

  // Source ports, in the rotation order.
  typedef enum logic [2:0] {
    portL    = 3'd0,
    portN    = 3'd1,
    portE    = 3'd2,
    portW    = 3'd3,
    portS    = 3'd4,
    portNone = 3'd5
  } portId;

  // One-hot, grant state of port i sits at bit i+1.
  typedef enum logic [5:0] {
    stIdle   = 6'b000001,
    stGrantL = 6'b000010,
    stGrantN = 6'b000100,
    stGrantE = 6'b001000,
    stGrantW = 6'b010000,
    stGrantS = 6'b100000
  } arbState;

  // A head flit carries the packet length in the low LengthWidth payload bits.
  typedef struct packed {
    flitKind kind;
    logic [DefaultDataWidth-1:0] payload;
  } flit_t;

endpackage

// ==== source/flitStager.sv ====
`timescale 1ns/1ps

module flitStager #(
  parameter int DataWidth = 16
) (
  input  logic clk,
  input  logic rst,
  input  nocPkg::flit_t inFlit,
  output nocPkg::flit_t staged,
  output logic req,
  output logic [nocPkg::LengthWidth-1:0] length,
  output logic loadLength
);

  nocPkg::flitKind kindQ;
  logic [DataWidth-1:0] payloadQ;

  // **************************************************************************
  // Input register.
  // **************************************************************************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      kindQ <= nocPkg::kindNone;
    end
    else
    begin
      kindQ <= inFlit.kind;
    end
  end

  always_ff @(posedge clk)
  begin
    payloadQ <= inFlit.payload;
  end

  assign staged = '{kind: kindQ, payload: payloadQ};

  // **************************************************************************
  // Request and header length.
  // **************************************************************************

  assign req = (kindQ != nocPkg::kindNone); // Any flit asks for the output.

  // Length is only meaningful on a head flit.
  assign length = payloadQ[nocPkg::LengthWidth-1:0];
  assign loadLength = (kindQ == nocPkg::kindHead);

endmodule

// ==== source/holdTimer.sv ====
`timescale 1ns/1ps

module holdTimer (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::LengthWidth-1:0] length,
  input  logic loadLength,
  input  logic run,
  output logic timesup
);

  logic [nocPkg::LengthWidth-1:0] limit;
  logic [nocPkg::LengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (loadLength)
      begin
        limit <= length; // New packet sets its own hold time.
      end
      if (run)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0; // Not holding, start over next time.
      end
    end
  end

  assign timesup = (count == limit);

endmodule

// ==== source/outputArbiter.sv ====
`timescale 1ns/1ps

module outputArbiter (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::PortCount-1:0] req,
  input  logic [nocPkg::PortCount-1:0][nocPkg::LengthWidth-1:0] length,
  input  logic [nocPkg::PortCount-1:0] loadLength,
  output nocPkg::portId nextGrant
);

  nocPkg::arbState state;
  nocPkg::arbState stateNext;
  logic [2:0] holderIdx;
  logic holding;
  logic [nocPkg::PortCount-1:0] runTimer;
  logic [nocPkg::PortCount-1:0] timesup;

  // First requester found when searching cyclically from port first.
  function automatic nocPkg::arbState pickFrom(input logic [nocPkg::PortCount-1:0] reqs,
                                               input int unsigned first);
    int unsigned idx;
    nocPkg::arbState pick;
    pick = nocPkg::stIdle;
    // Walk backwards so the nearest requester is written last.
    for (int n = nocPkg::PortCount - 1; n >= 0; n--)
    begin
      idx = (first + n) % nocPkg::PortCount;
      if (reqs[idx])
      begin
        pick = nocPkg::arbState'(6'b000010 << idx);
      end
    end
    return pick;
  endfunction

  // **************************************************************************
  // Hold timers, one per input.
  // **************************************************************************

  for (genvar i = 0; i < nocPkg::PortCount; i++)
  begin : genTimer
    holdTimer holdTimer_inst (
      .clk(clk),
      .rst(rst),
      .length(length[i]),
      .loadLength(loadLength[i]),
      .run(runTimer[i]),
      .timesup(timesup[i])
    );
  end

  // **************************************************************************
  // Grant state machine.
  // **************************************************************************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= nocPkg::stIdle;
    end
    else
    begin
      state <= stateNext;
    end
  end

  always_comb
  begin
    holding = 1'b1;
    holderIdx = 3'd0;
    case (state)
      nocPkg::stGrantL: holderIdx = 3'd0;
      nocPkg::stGrantN: holderIdx = 3'd1;
      nocPkg::stGrantE: holderIdx = 3'd2;
      nocPkg::stGrantW: holderIdx = 3'd3;
      nocPkg::stGrantS: holderIdx = 3'd4;
      default:          holding = 1'b0;
    endcase
  end

  always_comb
  begin
    runTimer = '0;
    stateNext = nocPkg::stIdle;
    if (!holding)
    begin
      stateNext = pickFrom(req, 0); // Fixed L..S priority from idle.
    end
    else if (req[holderIdx] && !timesup[holderIdx])
    begin
      stateNext = state;
      runTimer[holderIdx] = 1'b1;
    end
    else
    begin
      // Holder goes last.
      stateNext = pickFrom(req, int'(holderIdx) + 1);
    end
  end

  always_comb
  begin
    case (stateNext)
      nocPkg::stGrantL: nextGrant = nocPkg::portL;
      nocPkg::stGrantN: nextGrant = nocPkg::portN;
      nocPkg::stGrantE: nextGrant = nocPkg::portE;
      nocPkg::stGrantW: nextGrant = nocPkg::portW;
      nocPkg::stGrantS: nextGrant = nocPkg::portS;
      default:          nextGrant = nocPkg::portNone;
    endcase
  end

endmodule

// ==== source/switchStage.sv ====
`timescale 1ns/1ps

module switchStage #(
  parameter int DataWidth = 16
) (
  input  logic clk,
  input  logic rst,
  input  nocPkg::flit_t [nocPkg::PortCount-1:0] staged,
  input  nocPkg::portId nextGrant,
  output nocPkg::flit_t outFlit,
  output nocPkg::portId outPort
);

  nocPkg::flit_t selected;
  nocPkg::flitKind outKind;
  logic [DataWidth-1:0] outPayload;

  always_comb
  begin
    selected = '{kind: nocPkg::kindNone, payload: '0};
    if (nextGrant != nocPkg::portNone)
    begin
      selected = staged[nextGrant];
    end
  end

  // **************************************************************************
  // Output register.
  // **************************************************************************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outKind <= nocPkg::kindNone;
      outPort <= nocPkg::portNone;
    end
    else
    begin
      outKind <= selected.kind;
      outPort <= nextGrant; // Source port travels with the flit.
    end
  end

  always_ff @(posedge clk)
  begin
    outPayload <= selected.payload;
  end

  assign outFlit = '{kind: outKind, payload: outPayload};

endmodule

// ==== source/routerOutputPort.sv ====
`timescale 1ns/1ps

module routerOutputPort #(
  parameter int DataWidth = 16
) (
  input  logic clk,
  input  logic rst,
  input  nocPkg::flit_t inL,
  input  nocPkg::flit_t inN,
  input  nocPkg::flit_t inE,
  input  nocPkg::flit_t inW,
  input  nocPkg::flit_t inS,
  output nocPkg::flit_t outFlit,
  output nocPkg::portId outPort
);

  nocPkg::flit_t [nocPkg::PortCount-1:0] inFlits;
  nocPkg::flit_t [nocPkg::PortCount-1:0] staged;
  logic [nocPkg::PortCount-1:0] req;
  logic [nocPkg::PortCount-1:0][nocPkg::LengthWidth-1:0] length;
  logic [nocPkg::PortCount-1:0] loadLength;
  nocPkg::portId nextGrant;

  // Index follows portId, L at 0.
  assign inFlits = {inS, inW, inE, inN, inL};

  // **************************************************************************
  // Stage 1, input staging.
  // **************************************************************************

  for (genvar i = 0; i < nocPkg::PortCount; i++)
  begin : genStager
    flitStager #(
      .DataWidth(DataWidth)
    ) flitStager_inst (
      .clk(clk),
      .rst(rst),
      .inFlit(inFlits[i]),
      .staged(staged[i]),
      .req(req[i]),
      .length(length[i]),
      .loadLength(loadLength[i])
    );
  end

  // Stage 2, arbitration.
  outputArbiter outputArbiter_inst (
    .clk(clk),
    .rst(rst),
    .req(req),
    .length(length),
    .loadLength(loadLength),
    .nextGrant(nextGrant)
  );

  // Stage 3, switch and output register.
  switchStage #(
    .DataWidth(DataWidth)
  ) switchStage_inst (
    .clk(clk),
    .rst(rst),
    .staged(staged),
    .nextGrant(nextGrant),
    .outFlit(outFlit),
    .outPort(outPort)
  );

endmodule

// ==== sim/outputPortTb.sv ====
`timescale 1ns/1ps

module outputPortTb;

  localparam int ClockPeriod = 100;
  localparam int InputDelay = 10;
  localparam int MaxCycles = 256;
  localparam int MaxTests = 32;

  // One cycle of the case file, inputs and the outputs expected in that cycle.
  typedef struct packed {
    logic [19:0] flitL;
    logic [19:0] flitN;
    logic [19:0] flitE;
    logic [19:0] flitW;
    logic [19:0] flitS;
    logic [3:0] expPort;
    logic [19:0] expFlit;
  } cycleCase_t;

  logic clk;
  logic rst;
  nocPkg::flit_t inL;
  nocPkg::flit_t inN;
  nocPkg::flit_t inE;
  nocPkg::flit_t inW;
  nocPkg::flit_t inS;
  nocPkg::flit_t outFlit;
  nocPkg::portId outPort;

  cycleCase_t caseLines [MaxCycles];
  int caseTest [MaxCycles];
  string testNames [MaxTests];
  int cycleCount;
  int testCount;
  bit casesLoaded;
  int errorCount;
  int testErrors;
  int testCycles;

  routerOutputPort #(
    .DataWidth(16)
  ) routerOutputPort_inst (
    .clk(clk),
    .rst(rst),
    .inL(inL),
    .inN(inN),
    .inE(inE),
    .inW(inW),
    .inS(inS),
    .outFlit(outFlit),
    .outPort(outPort)
  );

  always #(ClockPeriod / 2) clk = ~clk;

  // **************************************************************************
  // Case file, checks and reporting.
  // **************************************************************************

  task automatic loadCases(output bit ok);
    int fd;
    int count;
    string line;
    string keyword;
    string name;
    logic [19:0] fields [7];
    ok = 1'b1;
    cycleCount = 0;
    testCount = 0;
    fd = $fopen("sim/portCases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the case file sim/portCases.txt");
      ok = 1'b0;
    end
    else
    begin
      while (ok && !$feof(fd))
      begin
        line = "";
        count = $fgets(line, fd);
        if (count > 0 && $sscanf(line, "%s", keyword) == 1)
        begin
          if (keyword == "test")
          begin
            if ($sscanf(line, "%s %s", keyword, name) == 2 && testCount < MaxTests)
            begin
              testNames[testCount] = name;
              testCount++;
            end
            else
            begin
              $display("Bad test line in the case file: %s", line);
              ok = 1'b0;
            end
          end
          else if (keyword.getc(0) != "#") // Comment lines are skipped.
          begin
            count = $sscanf(line, "%h %h %h %h %h %h %h", fields[0], fields[1],
                            fields[2], fields[3], fields[4], fields[5], fields[6]);
            if (count != 7 || testCount == 0 || cycleCount == MaxCycles)
            begin
              $display("Bad cycle line in the case file: %s", line);
              ok = 1'b0;
            end
            else
            begin
              caseLines[cycleCount] = '{flitL: fields[0], flitN: fields[1],
                                        flitE: fields[2], flitW: fields[3],
                                        flitS: fields[4], expPort: fields[5][3:0],
                                        expFlit: fields[6]};
              caseTest[cycleCount] = testCount - 1;
              cycleCount++;
            end
          end
        end
      end
      $fclose(fd);
      if (ok && cycleCount == 0)
      begin
        $display("The case file holds no cycles");
        ok = 1'b0;
      end
    end
  endtask

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("FAILED at time %0d ns: %s is %0h, expected %0h", $time, what, actual,
               expected);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic checkOutputs(input cycleCase_t c, input int idx);
    string where;
    where = $sformatf("%s cycle %0d", testNames[caseTest[idx]], idx);
    checkValue(outPort, c.expPort, {where, " outPort"});
    checkValue(outFlit.kind, c.expFlit[18:16], {where, " kind"});
    checkValue(outFlit.payload, c.expFlit[15:0], {where, " payload"});
  endtask

  task automatic applyInputs(input cycleCase_t c);
    inL = c.flitL[18:0];
    inN = c.flitN[18:0];
    inE = c.flitE[18:0];
    inW = c.flitW[18:0];
    inS = c.flitS[18:0];
  endtask

  task automatic reportTest(input int t);
    $display("Test %s finished: %0d cycles, %0d mismatches", testNames[t], testCycles,
             testErrors);
  endtask

  // **************************************************************************
  // Stimulus.
  // **************************************************************************

  initial
  begin
    bit ok;
    int lastTest;
    clk = 1'b0;
    rst = 1'b1;
    inL = '0;
    inN = '0;
    inE = '0;
    inW = '0;
    inS = '0;
    errorCount = 0;
    testErrors = 0;
    testCycles = 0;
    casesLoaded = 1'b0;
    loadCases(ok);
    casesLoaded = ok;
    if (!ok)
    begin
      $display("Result: FAILED");
      $finish;
    end
    else
    begin
      repeat (5) @(posedge clk);
      #(InputDelay);
      rst = 1'b0;
      lastTest = -1;
      // Each line expects the output of the inputs two lines earlier.
      for (int i = 0; i < cycleCount; i++)
      begin
        if (caseTest[i] != lastTest)
        begin
          if (lastTest >= 0)
          begin
            reportTest(lastTest);
          end
          lastTest = caseTest[i];
          testErrors = 0;
          testCycles = 0;
        end
        checkOutputs(caseLines[i], i);
        applyInputs(caseLines[i]);
        testCycles++;
        @(posedge clk);
        #(InputDelay);
      end
      reportTest(lastTest);
      $display("Totals: %0d tests, %0d cycles, %0d mismatches", testCount, cycleCount,
               errorCount);
      if (errorCount == 0)
      begin
        $display("Result: PASSED");
      end
      else
      begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

  initial
  begin
    wait (casesLoaded);
    #((cycleCount + 20) * ClockPeriod); // Margin covers reset and pipeline.
    $display("Watchdog expired after %0d cycles, the run did not complete",
             cycleCount + 20);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== sim/portCases.txt ====
# Columns: input flits L N E W S, then expected outPort and outFlit, all hex.
# A flit is one kind digit and four payload digits; outputs lag inputs two lines.
# A line starting with test names the group of cycle lines that follows.
test resetIdle
00000 00000 00000 00000 00000 5 00000
00000 00000 00000 00000 00000 5 00000
00000 00000 00000 00000 00000 5 00000
test priorityOrder
1000F 1000F 1000F 1000F 1000F 5 00000
2A104 2B104 2C104 2D104 2E104 5 00000
00000 3B105 2C105 2D105 2E105 0 1000F
00000 00000 3C106 2D106 2E106 0 2A104
00000 00000 00000 3D107 2E107 1 3B105
00000 00000 00000 00000 3E108 2 3C106
00000 00000 00000 00000 00000 3 3D107
00000 00000 00000 00000 00000 4 3E108
test holdTimeout
00000 00000 10003 00000 00000 5 00000
00000 00000 2C112 10009 00000 5 00000
00000 00000 2C113 2D113 00000 2 10003
00000 00000 2C114 2D114 00000 2 2C112
2A115 00000 2C115 2D115 00000 2 2C113
2A116 00000 3C116 2D116 00000 2 2C114
2A117 00000 00000 3D117 00000 3 2D115
00000 00000 00000 00000 00000 3 2D116
test rotationWrap
00000 00000 00000 00000 10001 3 3D117
00000 2B120 00000 2D120 2E120 5 00000
10000 2B121 00000 2D121 2E121 4 10001
3A122 2B122 00000 2D122 3E122 4 2E120
00000 3B123 00000 3D123 00000 0 10000
00000 00000 00000 00000 00000 1 2B122
test dropEarly
00000 00000 00000 10008 00000 1 3B123
00000 00000 2C126 2D126 00000 5 00000
00000 00000 2C127 00000 00000 3 10008
00000 00000 00000 00000 00000 3 2D126
00000 00000 00000 00000 00000 2 2C127
00000 00000 00000 00000 00000 5 00000
test payloadPass
00000 1F00A 2C131 00000 00000 5 00000
00000 2FFFF 2C132 00000 00000 5 00000
00000 25A5A 2C133 00000 00000 1 1F00A
00000 28000 3C134 00000 00000 1 2FFFF
00000 30001 00000 00000 00000 1 25A5A
00000 00000 00000 00000 00000 1 28000
00000 00000 00000 00000 00000 1 30001
00000 00000 00000 00000 00000 5 00000

// ==== list.f ====
source/nocPkg.sv
source/flitStager.sv
source/holdTimer.sv
source/outputArbiter.sv
source/switchStage.sv
source/routerOutputPort.sv
sim/outputPortTb.sv

// ==== Bender.yml ====
package:
  name: router_output_port

sources:
  - files:
      - source/nocPkg.sv
      - source/flitStager.sv
      - source/holdTimer.sv
      - source/outputArbiter.sv
      - source/switchStage.sv
      - source/routerOutputPort.sv
  - target: simulation
    files:
      - sim/outputPortTb.sv
